// File: common/sdmac_pkg.sv
// SDMAC shared definitions for port codes, register indexes and datapath widths
package sdmac_pkg;

    // Peripheral ports in word-index order (index minus 4)
    typedef enum logic [1:0] {
        port_scsi = 2'd0,   // Port 0, WD33C93A
        port_x1a  = 2'd1,   // Port 1A, 8-bit
        port_x2   = 2'd2,   // Port 2, 8-bit
        port_x1b  = 2'd3    // Port 1B, 16-bit
    } port_sel_t;

    // Internal register word indexes, cpu_addr[4:2]
    localparam logic [2:0] REG_DMA_ADDR  = 3'd0;   // Memory start address
    localparam logic [2:0] REG_DMA_COUNT = 3'd1;   // Byte count
    localparam logic [2:0] REG_DMA_CTRL  = 3'd2;   // Start on write, busy/done on read
    localparam logic [2:0] REG_SCRATCH   = 3'd3;   // Spare

    // Memory side address width
    localparam int MEM_ADDR_W = 16;

    // DMA byte counter width
    localparam int COUNT_W = 16;

endpackage

// File: io_port/io_port.sv
// Peripheral bus sequencer, one strobed access per acc_go with chip select decode and lane copy
module io_port #(
    parameter int STROBE_CYCLES = 3                 // Strobe length in CLK cycles, min 1
) (
    input  logic                 CLK,
    input  logic                 _AS,
    input  logic                 acc_go,            // Start of one access
    input  sdmac_pkg::port_sel_t acc_port,
    input  logic                 acc_write,
    input  logic [15:0]          acc_wdata,         // Already lane formatted
    input  logic [15:0]          p_rdata,
    output logic                 port_done,         // One cycle after strobes end
    output logic [31:0]          port_rdata,        // Replicated to CPU lanes
    output logic [15:0]          p_wdata,
    output logic                 p_oe,
    output logic                 css_n,             // Port 0
    output logic                 csx0_n,            // Ports 1A and 1B
    output logic                 csx1_n,            // Port 2
    output logic                 ior_n,
    output logic                 iow_n
);

    localparam int CNT_W = (STROBE_CYCLES > 1) ? $clog2(STROBE_CYCLES) : 1;

    logic                 active;                  // Strobes asserted
    logic [CNT_W-1:0]     cnt;                     // Strobe cycles left minus one
    sdmac_pkg::port_sel_t port_q;                  // Port of access in flight
    logic                 last;

    assign last = active && (cnt == '0);           // Final strobe cycle

    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            active    <= 1'b0;
            cnt       <= '0;
            port_done <= 1'b0;
            css_n     <= 1'b1;
            csx0_n    <= 1'b1;
            csx1_n    <= 1'b1;
            ior_n     <= 1'b1;
            iow_n     <= 1'b1;
            p_oe      <= 1'b0;
        end else begin
            port_done <= last;
            if (acc_go) begin
                active <= 1'b1;
                cnt    <= CNT_W'(STROBE_CYCLES - 1);
                css_n  <= (acc_port != sdmac_pkg::port_scsi);
                csx0_n <= !acc_port[0];                        // 1A and 1B share a select
                csx1_n <= (acc_port != sdmac_pkg::port_x2);
                ior_n  <= acc_write;
                iow_n  <= !acc_write;
                p_oe   <= acc_write;                           // Drive bus on writes only
            end else if (last) begin
                active <= 1'b0;
                css_n  <= 1'b1;
                csx0_n <= 1'b1;
                csx1_n <= 1'b1;
                ior_n  <= 1'b1;
                iow_n  <= 1'b1;
                p_oe   <= 1'b0;
            end else if (active) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Access payload and read capture
    always_ff @(posedge CLK) begin
        if (acc_go) begin
            port_q  <= acc_port;
            p_wdata <= acc_wdata;
        end
        if (last) begin
            if (port_q == sdmac_pkg::port_x1b)
                port_rdata <= {p_rdata, p_rdata};             // Halfword twice
            else
                port_rdata <= {4{p_rdata[7:0]}};              // Byte in every lane
        end
    end

endmodule

// File: hw/cpu_slave.sv
// CPU slave that answers DMA registers directly and turns port addresses into bus requests
module cpu_slave (
    input  logic                                 CLK,
    input  logic                                 _AS,
    input  logic                                 cpu_sel,
    input  logic                                 cpu_rw,       // 1 read, 0 write
    input  logic [4:0]                           cpu_addr,
    input  logic [31:0]                          cpu_wdata,
    input  logic [31:0]                          port_rdata,
    input  logic                                 port_done,
    input  logic                                 cpu_grant,
    input  logic                                 busy,
    input  logic                                 done,
    output logic [31:0]                          cpu_rdata,
    output logic                                 cpu_ack,
    output logic                                 cpu_port16,   // Port 1B answered
    output logic                                 cpu_req,
    output sdmac_pkg::port_sel_t                 cpu_port,
    output logic                                 cpu_write,
    output logic [15:0]                          cpu_pwdata,
    output logic                                 dma_start,
    output logic [sdmac_pkg::MEM_ADDR_W-1:0]     dma_base,
    output logic [sdmac_pkg::COUNT_W-1:0]        dma_len
);

    typedef enum logic [1:0] {
        S_IDLE,         // Waiting for cpu_sel
        S_PORT,         // Port request held
        S_RELEASE       // Acked and waiting for cpu_sel low
    } state_t;

    state_t      state;
    logic [2:0]  idx;
    logic        reg_hit;
    logic        port_hit;
    logic        port_end;
    logic [31:0] scratch;
    logic [31:0] reg_rdata;

    assign idx      = cpu_addr[4:2];                               // Word index
    assign reg_hit  = (state == S_IDLE) && cpu_sel && !cpu_addr[4];
    assign port_hit = (state == S_IDLE) && cpu_sel && cpu_addr[4];
    assign port_end = (state == S_PORT) && port_done && cpu_grant;

    always_comb begin
        case (idx)
            sdmac_pkg::REG_DMA_ADDR:  reg_rdata = 32'(dma_base);
            sdmac_pkg::REG_DMA_COUNT: reg_rdata = 32'(dma_len);
            sdmac_pkg::REG_DMA_CTRL:  reg_rdata = {30'd0, done, busy};
            default:                  reg_rdata = scratch;
        endcase
    end

    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            state      <= S_IDLE;
            cpu_ack    <= 1'b0;
            cpu_port16 <= 1'b0;
            cpu_req    <= 1'b0;
            dma_start  <= 1'b0;
            dma_base   <= '0;
            dma_len    <= '0;
        end else begin
            cpu_ack   <= 1'b0;
            dma_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (reg_hit) begin
                        cpu_ack    <= 1'b1;                          // One cycle register access
                        cpu_port16 <= 1'b0;
                        state      <= S_RELEASE;
                        if (!cpu_rw) begin
                            case (idx)
                                sdmac_pkg::REG_DMA_ADDR:
                                    dma_base <= cpu_wdata[sdmac_pkg::MEM_ADDR_W-1:0];
                                sdmac_pkg::REG_DMA_COUNT:
                                    dma_len <= cpu_wdata[sdmac_pkg::COUNT_W-1:0];
                                sdmac_pkg::REG_DMA_CTRL:
                                    dma_start <= cpu_wdata[0];
                                default: ;                           // Scratch in payload block
                            endcase
                        end
                    end else if (port_hit) begin
                        cpu_req <= 1'b1;
                        state   <= S_PORT;
                    end
                end
                S_PORT: begin
                    if (port_end) begin
                        cpu_req    <= 1'b0;                          // Drop after port_done
                        cpu_ack    <= 1'b1;
                        cpu_port16 <= (cpu_port == sdmac_pkg::port_x1b);
                        state      <= S_RELEASE;
                    end
                end
                default: begin
                    if (!cpu_sel)
                        state <= S_IDLE;
                end
            endcase
        end
    end

    // Read data, scratch register and port request payload
    always_ff @(posedge CLK) begin
        if (reg_hit)
            cpu_rdata <= reg_rdata;
        else if (port_end)
            cpu_rdata <= port_rdata;
        if (reg_hit && !cpu_rw && (idx == sdmac_pkg::REG_SCRATCH))
            scratch <= cpu_wdata;
        if (port_hit) begin
            cpu_port  <= sdmac_pkg::port_sel_t'(cpu_addr[3:2]);       // Index minus 4
            cpu_write <= !cpu_rw;
            if (cpu_addr[3:2] == 2'd3)
                cpu_pwdata <= cpu_wdata[31:16];                       // Port 1B upper half
            else
                cpu_pwdata <= {2{cpu_wdata[7:0]}};                    // Byte on both lanes
        end
    end

endmodule

// File: dma/dma_engine.sv
// DMA engine moving bytes from SCSI port 0 into the memory write stream
module dma_engine (
    input  logic                                 CLK,
    input  logic                                 _AS,
    input  logic                                 dma_start,
    input  logic [sdmac_pkg::MEM_ADDR_W-1:0]     dma_base,
    input  logic [sdmac_pkg::COUNT_W-1:0]        dma_len,
    input  logic                                 dma_grant,
    input  logic [31:0]                          port_rdata,
    input  logic                                 port_done,
    output logic                                 dma_req,     // Port 0 read request
    output logic                                 busy,
    output logic                                 done,        // Held until next start
    output logic                                 mem_we,
    output logic [sdmac_pkg::MEM_ADDR_W-1:0]     mem_addr,
    output logic [7:0]                           mem_wdata
);

    localparam logic [sdmac_pkg::COUNT_W-1:0] LAST_BYTE = 1;

    typedef enum logic [1:0] {
        D_IDLE,
        D_REQ,          // Waiting for port read
        D_WRITE         // mem_we cycle
    } dstate_t;

    dstate_t                        state;
    logic [sdmac_pkg::COUNT_W-1:0]  count_q;                  // Bytes still to move
    logic                           start_ok;
    logic                           byte_in;

    assign start_ok = (state == D_IDLE) && dma_start;         // Start ignored while busy
    assign byte_in  = (state == D_REQ) && port_done && dma_grant;

    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            state   <= D_IDLE;
            count_q <= '0;
            dma_req <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            mem_we <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (start_ok) begin
                        count_q <= dma_len;
                        if (dma_len == '0) begin
                            done <= 1'b1;                      // Nothing to move
                        end else begin
                            done    <= 1'b0;
                            busy    <= 1'b1;
                            dma_req <= 1'b1;
                            state   <= D_REQ;
                        end
                    end
                end
                D_REQ: begin
                    if (byte_in) begin
                        dma_req <= 1'b0;
                        mem_we  <= 1'b1;                       // One cycle after port_done
                        state   <= D_WRITE;
                    end
                end
                default: begin
                    count_q <= count_q - 1'b1;
                    if (count_q == LAST_BYTE) begin
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= D_IDLE;
                    end else begin
                        dma_req <= 1'b1;                       // Next byte
                        state   <= D_REQ;
                    end
                end
            endcase
        end
    end

    // Address pointer and byte buffer
    always_ff @(posedge CLK) begin
        if (start_ok)
            mem_addr <= dma_base;
        else if (state == D_WRITE)
            mem_addr <= mem_addr + 1'b1;                       // Advance after the write
        if (byte_in)
            mem_wdata <= port_rdata[7:0];
    end

endmodule

// File: hw/port_arbiter.sv
// Fixed-priority peripheral bus arbiter, CPU over DMA, one access in flight
module port_arbiter (
    input  logic                 CLK,
    input  logic                 _AS,
    input  logic                 cpu_req,
    input  logic                 dma_req,
    input  logic                 port_done,
    input  sdmac_pkg::port_sel_t cpu_port,
    input  logic                 cpu_write,
    input  logic [15:0]          cpu_pwdata,
    output logic                 cpu_grant,
    output logic                 dma_grant,
    output logic                 acc_go,        // One cycle, starts io_port
    output sdmac_pkg::port_sel_t acc_port,
    output logic                 acc_write,
    output logic [15:0]          acc_wdata
);

    logic bus_free;

    assign bus_free = !cpu_grant && !dma_grant;

    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            cpu_grant <= 1'b0;
            dma_grant <= 1'b0;
            acc_go    <= 1'b0;
        end else begin
            acc_go <= 1'b0;
            if (bus_free) begin
                if (cpu_req) begin
                    cpu_grant <= 1'b1;                 // CPU wins ties
                    acc_go    <= 1'b1;
                end else if (dma_req) begin
                    dma_grant <= 1'b1;
                    acc_go    <= 1'b1;
                end
            end else if (port_done) begin
                cpu_grant <= 1'b0;                     // Release with the access
                dma_grant <= 1'b0;
            end
        end
    end

    // Owner mux, DMA always reads port 0
    always_comb begin
        if (dma_grant) begin
            acc_port  = sdmac_pkg::port_scsi;
            acc_write = 1'b0;
            acc_wdata = 16'h0000;
        end else begin
            acc_port  = cpu_port;
            acc_write = cpu_write;
            acc_wdata = cpu_pwdata;
        end
    end

endmodule

// File: hw/sdmac_top.sv
// SDMAC top level connecting CPU slave, DMA engine, bus arbiter and peripheral port
module sdmac_top #(
    parameter int STROBE_CYCLES = 3
) (
    input  logic                              CLK,
    input  logic                              _AS,
    input  logic                              cpu_sel,
    input  logic                              cpu_rw,
    input  logic [4:0]                        cpu_addr,
    input  logic [31:0]                       cpu_wdata,
    output logic [31:0]                       cpu_rdata,
    output logic                              cpu_ack,
    output logic                              cpu_port16,
    input  logic [15:0]                       p_rdata,
    output logic [15:0]                       p_wdata,
    output logic                              p_oe,
    output logic                              css_n,
    output logic                              csx0_n,
    output logic                              csx1_n,
    output logic                              ior_n,
    output logic                              iow_n,
    output logic                              mem_we,
    output logic [sdmac_pkg::MEM_ADDR_W-1:0]  mem_addr,
    output logic [7:0]                        mem_wdata,
    output logic                              dma_done
);

    logic                                 cpu_req, cpu_write, cpu_grant;
    logic                                 dma_req, dma_grant, dma_start, busy;
    logic                                 acc_go, acc_write, port_done;
    sdmac_pkg::port_sel_t                 cpu_port, acc_port;
    logic [15:0]                          cpu_pwdata, acc_wdata;
    logic [31:0]                          port_rdata;
    logic [sdmac_pkg::MEM_ADDR_W-1:0]     dma_base;
    logic [sdmac_pkg::COUNT_W-1:0]        dma_len;

    cpu_slave cpu_slave_inst (
        .CLK, ._AS, .cpu_sel, .cpu_rw, .cpu_addr, .cpu_wdata,
        .port_rdata, .port_done, .cpu_grant, .busy, .done(dma_done),
        .cpu_rdata, .cpu_ack, .cpu_port16, .cpu_req, .cpu_port, .cpu_write,
        .cpu_pwdata, .dma_start, .dma_base, .dma_len
    );

    dma_engine dma_engine_inst (
        .CLK, ._AS, .dma_start, .dma_base, .dma_len, .dma_grant,
        .port_rdata, .port_done, .dma_req, .busy, .done(dma_done),
        .mem_we, .mem_addr, .mem_wdata
    );

    port_arbiter port_arbiter_inst (
        .CLK, ._AS, .cpu_req, .dma_req, .port_done, .cpu_port, .cpu_write,
        .cpu_pwdata, .cpu_grant, .dma_grant, .acc_go, .acc_port, .acc_write, .acc_wdata
    );

    io_port #(
        .STROBE_CYCLES(STROBE_CYCLES)
    ) io_port_inst (
        .CLK, ._AS, .acc_go, .acc_port, .acc_write, .acc_wdata, .p_rdata,
        .port_done, .port_rdata, .p_wdata, .p_oe, .css_n, .csx0_n, .csx1_n,
        .ior_n, .iow_n
    );

endmodule

// File: test/sdmac_props.sv
// SDMAC bus properties on peripheral strobes, chip selects and CPU acknowledge
module sdmac_props (
    input logic CLK,
    input logic _AS,
    input logic css_n,
    input logic csx0_n,
    input logic csx1_n,
    input logic ior_n,
    input logic iow_n,
    input logic cpu_ack
);
    timeunit 1ns;
    timeprecision 100ps;

    // Read and write strobes exclusive
    assert property (@(posedge CLK) disable iff (_AS) !(!ior_n && !iow_n))
        else $error("ior_n and iow_n low together");

    assert property (@(posedge CLK) disable iff (_AS)
        $countones({!css_n, !csx0_n, !csx1_n}) <= 1)
        else $error("More than one chip select low");

    // No strobe without a selected port
    assert property (@(posedge CLK) disable iff (_AS)
        (!ior_n || !iow_n) |-> ({css_n, csx0_n, csx1_n} != 3'b111))
        else $error("Strobe without chip select");

    assert property (@(posedge CLK) disable iff (_AS) cpu_ack |=> !cpu_ack)
        else $error("cpu_ack high for two cycles");

endmodule

bind sdmac_top sdmac_props sdmac_props_inst (
    .CLK, ._AS, .css_n, .csx0_n, .csx1_n, .ior_n, .iow_n, .cpu_ack
);

// File: test/tb_sdmac.sv
// SDMAC testbench with random CPU traffic, peripheral and memory models, and DMA bursts
module tb_sdmac;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'h9bd5_0f9b;
    localparam int CYCLE_LIMIT = 200 * 20 + 4 * 64 * 10;    // CPU ops plus DMA bursts

    logic CLK = 1'b0;
    logic _AS, cpu_sel, cpu_rw, cpu_ack, cpu_port16;
    logic [4:0] cpu_addr;
    logic [31:0] cpu_wdata, cpu_rdata;
    logic [15:0] p_rdata, p_wdata, mem_addr;
    logic p_oe, css_n, csx0_n, csx1_n, ior_n, iow_n, mem_we, dma_done;
    logic [7:0] mem_wdata;

    logic [31:0] rng = SEED, bus_seq = SEED, mem_seq = SEED;   // Stimulus, port 0 and checker
    logic [15:0] preg [3] = '{default: 16'h0};    // Peripheral model registers per chip select
    logic [15:0] exp_reg [3] = '{default: 16'h0};  // Expected peripheral contents
    logic [31:0] exp_scratch;
    logic [15:0] exp_addr = '0, exp_count = '0, exp_base = '0;
    logic [2:0]  exp_cs;                           // {css_n, csx0_n, csx1_n} of CPU access
    bit exp_wr, cs_seen, dma_mode = 0, rd_prev = 0;
    int errors = 0, checks = 0, cycles = 0, mem_count = 0;

    sdmac_top #(.STROBE_CYCLES(3)) sdmac_top_inst (.*);

    always #4 CLK = ~CLK;
    always @(posedge CLK) cycles <= cycles + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    // Peripheral model with port 0 streaming bytes while DMA runs
    assign p_rdata = !css_n  ? (dma_mode ? {8'h00, bus_seq[7:0]} : preg[0]) :
                     !csx0_n ? preg[1] : !csx1_n ? preg[2] : 16'h0000;

    always @(posedge CLK) begin
        rd_prev <= !ior_n && !css_n;
        if (dma_mode && rd_prev && !(!ior_n && !css_n))
            bus_seq <= xorshift32(bus_seq);                   // Next byte after each read
        if (!iow_n) begin
            if (!css_n)  preg[0] <= p_wdata;
            if (!csx0_n) preg[1] <= p_wdata;
            if (!csx1_n) preg[2] <= p_wdata;
        end
        if (!ior_n || !iow_n) begin
            check_value("chip selects low", 32'd1, 32'($countones({!css_n, !csx0_n, !csx1_n})));
            check_value("p_oe during strobe", 32'(!iow_n), 32'(p_oe));
            if ({css_n, csx0_n, csx1_n} == exp_cs && (!iow_n) == exp_wr)
                cs_seen <= 1'b1;                              // Right select and strobe
        end
        if (mem_we) begin
            check_value("mem_addr", 32'(16'(exp_base + mem_count)), 32'(mem_addr));
            check_value("mem_wdata", 32'(mem_seq[7:0]), 32'(mem_wdata));
            mem_seq   <= xorshift32(mem_seq);
            mem_count <= mem_count + 1;
        end
    end

    task automatic cpu_access(input bit rd, input logic [2:0] idx, input logic [31:0] wdata);
        int n;
        int grp;
        logic [31:0] exp;
        string name;
        n    = 0;
        grp  = (idx[1:0] == 2'd0) ? 0 : (idx[1:0] == 2'd2) ? 2 : 1;
        name = $sformatf("%s index %0d", rd ? "read" : "write", idx);
        exp_cs  = (idx[1:0] == 2'd0) ? 3'b011 : (idx[1:0] == 2'd2) ? 3'b110 : 3'b101;
        exp_wr  = !rd;
        cs_seen = 1'b0;
        cpu_sel   = 1'b1;
        cpu_rw    = rd;
        cpu_addr  = {idx, 2'b00};
        cpu_wdata = wdata;
        do begin
            @(negedge CLK);
            n++;
        end while (!cpu_ack);
        cpu_sel = 1'b0;
        if (!idx[2]) begin
            assert (n == 1) else begin
                errors++;
                $display("Register access %s acknowledged after %0d cycles, not 1", name, n);
            end
            case (idx)
                sdmac_pkg::REG_DMA_ADDR:  exp = {16'h0, exp_addr};
                sdmac_pkg::REG_DMA_COUNT: exp = {16'h0, exp_count};
                sdmac_pkg::REG_DMA_CTRL:  exp = 32'h2;       // Read only after a burst
                default:                  exp = exp_scratch;
            endcase
            if (rd)
                check_value(name, exp, cpu_rdata);
            else if (idx == sdmac_pkg::REG_DMA_ADDR)
                exp_addr = wdata[15:0];
            else if (idx == sdmac_pkg::REG_DMA_COUNT)
                exp_count = wdata[15:0];
            else if (idx == sdmac_pkg::REG_SCRATCH)
                exp_scratch = wdata;
        end else begin
            assert (cs_seen) else begin
                errors++;
                $display("Port access %s never showed its chip select with the right strobe", name);
            end
            check_value({name, " port16"}, 32'(idx == 3'd7), 32'(cpu_port16));
            if (rd) begin
                exp = (idx == 3'd7) ? {2{exp_reg[grp]}} : {4{exp_reg[grp][7:0]}};
                check_value(name, exp, cpu_rdata);
            end else begin
                exp_reg[grp] = (idx == 3'd7) ? wdata[31:16] : {2{wdata[7:0]}};
                check_value({name, " stored"}, 32'(exp_reg[grp]), 32'(preg[grp]));
            end
        end
        @(negedge CLK);                                       // Let the slave see cpu_sel low
    endtask

    task automatic random_op(input bit under_load);
        logic [31:0] r;
        logic [2:0] idx;
        r   = next_random();
        idx = under_load ? {1'b1, r[2:1]} : r[3:1];
        if (idx == 3'd4 && under_load)
            idx = sdmac_pkg::REG_SCRATCH;                     // Port 0 belongs to the DMA
        if (idx == sdmac_pkg::REG_DMA_CTRL)
            idx = sdmac_pkg::REG_SCRATCH;
        cpu_access(r[0], idx, next_random());
    endtask

    task automatic dma_burst(input int len, input int load_ops);
        logic [15:0] base;
        base      = 16'(next_random());
        exp_base  = base;
        mem_count = 0;
        cpu_access(1'b0, sdmac_pkg::REG_DMA_ADDR, 32'(base));
        cpu_access(1'b0, sdmac_pkg::REG_DMA_COUNT, 32'(len));
        cpu_access(1'b0, sdmac_pkg::REG_DMA_CTRL, 32'h1);
        repeat (load_ops) random_op(1'b1);
        while (!dma_done) @(negedge CLK);
        check_value("DMA byte count", 32'(len), 32'(mem_count));
        cpu_access(1'b1, sdmac_pkg::REG_DMA_CTRL, 32'h0);
    endtask

    initial begin
        wait (cycles >= CYCLE_LIMIT);
        $display("Timeout, run stopped after %0d cycles with %0d checks and %0d errors",
            cycles, checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        _AS = 1'b1;
        cpu_sel = 1'b0;
        cpu_rw = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        _AS = 1'b0;
        check_value("reset state", 32'h7c,
            32'({cpu_ack, mem_we, css_n, csx0_n, csx1_n, ior_n, iow_n, p_oe, dma_done}));
        cpu_access(1'b0, sdmac_pkg::REG_SCRATCH, next_random());
        for (int i = 4; i < 8; i++) begin
            cpu_access(1'b0, 3'(i), next_random());          // Write then read each port
            cpu_access(1'b1, 3'(i), 32'h0);
        end
        for (int i = 0; i < 4; i++) begin
            if (i == 2) continue;
            cpu_access(1'b0, 3'(i), next_random());
            cpu_access(1'b1, 3'(i), 32'h0);
        end
        repeat (40) random_op(1'b0);
        dma_mode = 1'b1;
        dma_burst(1 + int'(next_random() % 64), 0);
        dma_burst(1 + int'(next_random() % 64), 0);
        dma_burst(32 + int'(next_random() % 33), 12);        // CPU traffic during burst
        dma_burst(32 + int'(next_random() % 33), 12);
        $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: project.f
common/sdmac_pkg.sv
io_port/io_port.sv
hw/cpu_slave.sv
dma/dma_engine.sv
hw/port_arbiter.sv
hw/sdmac_top.sv
test/sdmac_props.sv
test/tb_sdmac.sv
